// ==== compile.f ====
hdl/fetch_pkg.sv
hdl/sync_fifo.sv
hdl/fetch_sequencer.sv
hdl/line_read_master.sv
hdl/descriptor_fetch.sv
verification/tb_clock_gen.sv
verification/tb_memory_model.sv
verification/tb_descriptor_fetch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the descriptor fetch testbench, the log decides the result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module tb_descriptor_fetch \
  -o sim_descriptor_fetch > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_descriptor_fetch > sim.log 2>&1 ; cat sim.log

grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0

// ==== verification/tb_descriptor_fetch.sv ====
module tb_descriptor_fetch
  import fetch_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int cycle_limit = 4000;  // the phases below take well under half of this
  localparam int max_lines = 32;

  logic     clk;
  logic     reset;
  address_t m_address;
  logic     m_read;
  line_t    m_readdata;
  logic     m_readdatavalid;
  logic     m_waitrequest;
  line_t    descriptor;
  logic     descriptor_valid;
  logic     descriptor_ready = 1'b0;
  address_t block_address;
  logic     block_address_valid;
  logic     block_address_ready = 1'b0;
  logic     enable_fetch = 1'b0;
  logic     flush = 1'b0;
  address_t new_descriptor_location = '0;
  logic     load_new_descriptor_location = 1'b0;
  timeout_t descriptor_timeout = '0;
  logic     enable_descriptor_timeout = 1'b0;
  logic     fetch_idle;

  integer   seed = 32'h5063_6429;
  logic     hold_desc = 1'b1;   // forces back-pressure on the descriptor stream
  logic     hold_block = 1'b0;  // forces back-pressure on the block address stream
  line_t    exp_desc [max_lines];
  address_t exp_block [max_lines];
  int       desc_total = 0;
  int       block_total = 0;
  int       desc_idx = 0;
  int       block_idx = 0;
  int       reads_accepted = 0;
  int       terminator_reads = 0;
  int       cycle_count = 0;
  int       errors = 0;
  line_t    expected_descriptor;
  address_t expected_block;

  tb_clock_gen u_clock (.clk(clk), .reset(reset));

  tb_memory_model #(.seed_init(32'h5063_6429)) u_memory (
    .clk(clk), .reset(reset), .m_address(m_address), .m_read(m_read),
    .m_waitrequest(m_waitrequest), .m_readdata(m_readdata), .m_readdatavalid(m_readdatavalid)
  );

  descriptor_fetch u_dut (.*);

  assign expected_descriptor = (desc_idx < max_lines) ? exp_desc[desc_idx] : '0;
  assign expected_block      = (block_idx < max_lines) ? exp_block[block_idx] : '0;

  // **************************************************
  // scoreboard counters
  // **************************************************
  always @(posedge clk)
  begin
    if (descriptor_valid && descriptor_ready)
    begin
      desc_idx <= desc_idx + 1;
    end
    if (block_address_valid && block_address_ready)
    begin
      block_idx <= block_idx + 1;
    end
    if (m_read && !m_waitrequest)
    begin
      reads_accepted <= reads_accepted + 1;
      if (m_address == 48'h5000)
      begin
        terminator_reads <= terminator_reads + 1;  // proves the retry reached the chain end
      end
    end
  end

  // readies change a little after the edge and never on it
  always @(posedge clk)
  begin
    #1;
    descriptor_ready    <= hold_desc ? 1'b0 : 1'($random(seed));
    block_address_ready <= hold_block ? 1'b0 : 1'($random(seed));
  end

  // **************************************************
  // checks
  // **************************************************
  a_descriptor_order: assert property (@(posedge clk) disable iff (reset)
    (descriptor_valid && descriptor_ready) |-> (descriptor == expected_descriptor))
    else
    begin
      errors = errors + 1;
      $display("ERR descriptor got %h expected %h", $sampled(descriptor),
               $sampled(expected_descriptor));
    end

  a_descriptor_owned: assert property (@(posedge clk) disable iff (reset)
    descriptor_valid |-> descriptor[owned_bit])
    else
    begin
      errors = errors + 1;
      $display("ERR descriptor unowned line %h", $sampled(descriptor));
    end

  a_descriptor_extra: assert property (@(posedge clk) disable iff (reset)
    (descriptor_valid && descriptor_ready) |-> (desc_idx < desc_total))
    else
    begin
      errors = errors + 1;
      $display("a descriptor arrived that the chain does not contain");
    end

  a_block_order: assert property (@(posedge clk) disable iff (reset)
    (block_address_valid && block_address_ready) |->
      ((block_idx < block_total) && (block_address == expected_block)))
    else
    begin
      errors = errors + 1;
      $display("ERR block_address got %h expected %h", $sampled(block_address),
               $sampled(expected_block));
    end

  // lines in flight plus lines held can never pass the buffer depth
  a_outstanding_bound: assert property (@(posedge clk) disable iff (reset)
    (reads_accepted - desc_idx) <= fifo_depth)
    else
    begin
      errors = errors + 1;
      $display("more reads outstanding than the descriptor buffer can hold");
    end

  a_idle_no_read: assert property (@(posedge clk) disable iff (reset || !enable_fetch)
    fetch_idle |-> !(m_read && !m_waitrequest))
    else
    begin
      errors = errors + 1;
      $display("a read was accepted while the engine reported idle");
    end

  a_stall_stable: assert property (@(posedge clk) disable iff (reset)
    (m_read && m_waitrequest) |=> (m_read && $stable(m_address)))
    else
    begin
      errors = errors + 1;
      $display("ERR m_address changed under waitrequest to %h", $sampled(m_address));
    end

  a_flush_clears: assert property (@(posedge clk) disable iff (reset)
    flush |=> (!descriptor_valid && !block_address_valid))
    else
    begin
      errors = errors + 1;
      $display("an output stream stayed valid after flush");
    end

  // **************************************************
  // chain building and waits
  // **************************************************
  task automatic place_block(input address_t start, input int lines, input address_t next);
    line_t    data;
    address_t a;
    for (int n = 0; n < lines; n++)
    begin
      a = start + address_t'(n * line_bytes);
      for (int w = 0; w < line_width / 32; w++)
      begin
        data[32*w +: 32] = $random(seed);
      end
      data[format_first_bit] = (n == 0);  // only the first line opens a block
      data[owned_bit]        = 1'b1;
      if (n == 0)
      begin
        data[block_size_lsb +: block_count_width] = block_count_t'(lines - 1);
        data[next_lsb +: address_width]           = next;
      end
      u_memory.lines[a[14:6]] = data;
      exp_desc[desc_total]    = data;
      desc_total++;
    end
    exp_block[block_total] = start;
    block_total++;
  endtask

  task automatic place_terminator(input address_t a);
    line_t data;
    for (int w = 0; w < line_width / 32; w++)
    begin
      data[32*w +: 32] = $random(seed);
    end
    data[format_first_bit]  = 1'b1;
    data[owned_bit]         = 1'b0;  // hardware does not own it so the chain ends here
    u_memory.lines[a[14:6]] = data;
  endtask

  task automatic load_location(input address_t a);
    new_descriptor_location      = a;
    load_new_descriptor_location = 1'b1;
    @(posedge clk);
    #1 load_new_descriptor_location = 1'b0;
  endtask

  task automatic wait_drained(input int limit);
    int n;
    n = 0;
    while (((desc_idx < desc_total) || (block_idx < block_total)) && (n < limit))
    begin
      @(posedge clk);
      n++;
    end
    if ((desc_idx < desc_total) || (block_idx < block_total))
    begin
      errors++;
      $display("only %0d of %0d descriptors and %0d of %0d block addresses arrived",
               desc_idx, desc_total, block_idx, block_total);
    end
  endtask

  task automatic wait_fetch_idle(input int limit);
    int n;
    n = 0;
    while (!fetch_idle && (n < limit))
    begin
      @(posedge clk);
      n++;
    end
    if (!fetch_idle)
    begin
      errors++;
      $display("the engine did not go idle at the end of the chain");
    end
  endtask

  task automatic wait_retry_reads(input int target, input int limit);
    int n;
    n = 0;
    while ((terminator_reads < target) && (n < limit))
    begin
      @(posedge clk);
      n++;
    end
    if (terminator_reads < target)
    begin
      errors++;
      $display("the chain end was read %0d times, no retry seen", terminator_reads);
    end
  endtask

  task automatic wait_outputs_valid(input int limit);
    int n;
    n = 0;
    while (!(descriptor_valid && block_address_valid) && (n < limit))
    begin
      @(posedge clk);
      n++;
    end
    if (!(descriptor_valid && block_address_valid))
    begin
      errors++;
      $display("the last block never reached the output buffers before the flush");
    end
  endtask

  // the run ends here if a wait above never returns
  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("run stopped after %0d cycles without finishing", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  initial
  begin
    @(negedge reset);
    @(posedge clk);
    #1;
    // chain of 1, 6 and 3 lines ending on an unowned line
    place_block(48'h1000, 1, 48'h2000);
    place_block(48'h2000, 6, 48'h3000);
    place_block(48'h3000, 3, 48'h4000);
    place_terminator(48'h4000);
    load_location(48'h1000);
    enable_fetch = 1'b1;
    repeat (300) @(posedge clk);  // descriptor stream blocked the whole time
    #1 hold_desc = 1'b0;
    wait_drained(400);
    wait_fetch_idle(200);
    repeat (30) @(posedge clk);  // idle engine must stay quiet
    #1;

    // the old chain end becomes a 2 line block and retries are on from here
    place_block(48'h4000, 2, 48'h5000);
    place_terminator(48'h5000);
    descriptor_timeout        = 16'd40;
    enable_descriptor_timeout = 1'b1;
    load_location(48'h4000);
    wait_drained(400);

    wait_retry_reads(2, 400);
    #1;
    place_block(48'h5000, 1, 48'h6000);
    place_terminator(48'h6000);
    wait_drained(400);

    repeat (20) @(posedge clk);
    #1;
    // one more block is left waiting in both buffers so the flush has entries to drop
    hold_desc  = 1'b1;
    hold_block = 1'b1;
    place_block(48'h6000, 1, 48'h7000);
    place_terminator(48'h7000);
    wait_outputs_valid(400);
    #1;
    enable_fetch = 1'b0;
    flush        = 1'b1;
    @(posedge clk);
    #1 flush = 1'b0;
    repeat (10) @(posedge clk);

    $display("errors: %0d  descriptors taken: %0d  block addresses taken: %0d",
             errors, desc_idx, block_idx);
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
    end
    else
    begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end
endmodule

// ==== verification/tb_memory_model.sv ====
// line wide memory behind a read port, random waitrequest and random in order latency
module tb_memory_model
  import fetch_pkg::*;
#(
  parameter int seed_init = 32'h5063_6429
)
(
  input  logic     clk,
  input  logic     reset,
  input  address_t m_address,
  input  logic     m_read,
  output logic     m_waitrequest,
  output line_t    m_readdata,
  output logic     m_readdatavalid
);
  timeunit 1ns;
  timeprecision 100ps;

  line_t    lines [512];          // the test writes the chain straight into this array
  address_t pending_address [$];  // accepted reads waiting for their data
  int       pending_due [$];
  integer   seed = seed_init ^ 32'h0000_00ff;
  int       cycle = 0;
  int       last_due = 0;
  int       due;
  logic     accept;
  address_t accept_address;

  initial
  begin
    m_waitrequest   = 1'b1;
    m_readdata      = '0;
    m_readdatavalid = 1'b0;
    for (int i = 0; i < 512; i++)
    begin
      lines[i] = {16{32'(i) * 32'h9e37_79b9}};  // every line differs with its index
      lines[i][owned_bit] = 1'b0;               // empty memory never looks owned
    end
  end

  always @(posedge clk)
  begin
    accept         = m_read && !m_waitrequest;  // sampled before the DUT registers move
    accept_address = m_address;
    #1;
    cycle++;
    if (reset)
    begin
      pending_address.delete();
      pending_due.delete();
      m_waitrequest   = 1'b1;
      m_readdatavalid = 1'b0;
    end
    else
    begin
      if (accept)
      begin
        due = cycle + ($random(seed) & 7);  // zero to seven extra cycles
        if (due <= last_due)
        begin
          due = last_due + 1;  // one return per cycle keeps issue order
        end
        last_due = due;
        pending_address.push_back(accept_address);
        pending_due.push_back(due);
      end
      if ((pending_due.size() > 0) && (pending_due[0] <= cycle))
      begin
        m_readdata      = lines[pending_address[0][14:6]];  // content as it is on return
        m_readdatavalid = 1'b1;
        void'(pending_address.pop_front());
        void'(pending_due.pop_front());
      end
      else
      begin
        m_readdatavalid = 1'b0;
      end
      m_waitrequest = (($random(seed) & 3) == 0);  // stalls about one cycle in four
    end
  end
endmodule

// ==== verification/tb_clock_gen.sv ====
// free running clock and a reset that covers the first three edges
module tb_clock_gen
(
  output logic clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial
  begin
    reset = 1'b1;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;  // released just after the third edge like every other input
  end
endmodule

// ==== hdl/descriptor_fetch.sv ====
// descriptor fetch engine, follows a chain of descriptor blocks in host memory
module descriptor_fetch
  import fetch_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  // memory read port
  output address_t m_address,
  output logic     m_read,
  input  line_t    m_readdata,
  input  logic     m_readdatavalid,
  input  logic     m_waitrequest,
  // owned descriptors, exactly as read
  output line_t    descriptor,
  output logic     descriptor_valid,
  input  logic     descriptor_ready,
  // start address of every block that was found owned
  output address_t block_address,
  output logic     block_address_valid,
  input  logic     block_address_ready,
  // host control
  input  logic     enable_fetch,
  input  logic     flush,
  input  address_t new_descriptor_location,
  input  logic     load_new_descriptor_location,
  input  timeout_t descriptor_timeout,
  input  logic     enable_descriptor_timeout,
  output logic     fetch_idle
);

  fetch_state_t state;
  logic         read_stalled;
  logic         first_owned;
  logic         first_single;
  logic         first_unowned;
  logic         last_read_posted;
  logic         desc_write;
  logic         desc_empty;
  logic         desc_almost_full;
  logic         block_write;
  logic         block_empty;
  address_t     block_start;

  fetch_sequencer u_sequencer (
    .clk                          (clk),
    .reset                        (reset),
    .flush                        (flush),
    .enable_fetch                 (enable_fetch),
    .enable_descriptor_timeout    (enable_descriptor_timeout),
    .load_new_descriptor_location (load_new_descriptor_location),
    .descriptor_timeout           (descriptor_timeout),
    .read_stalled                 (read_stalled),
    .first_owned                  (first_owned),
    .first_single                 (first_single),
    .first_unowned                (first_unowned),
    .last_read_posted             (last_read_posted),
    .state                        (state),
    .fetch_idle                   (fetch_idle)
  );

  line_read_master u_read_master (
    .clk                          (clk),
    .reset                        (reset),
    .state                        (state),
    .new_descriptor_location      (new_descriptor_location),
    .load_new_descriptor_location (load_new_descriptor_location),
    .m_readdata                   (m_readdata),
    .m_readdatavalid              (m_readdatavalid),
    .m_waitrequest                (m_waitrequest),
    .desc_almost_full             (desc_almost_full),
    .m_address                    (m_address),
    .m_read                       (m_read),
    .read_stalled                 (read_stalled),
    .first_owned                  (first_owned),
    .first_single                 (first_single),
    .first_unowned                (first_unowned),
    .last_read_posted             (last_read_posted),
    .desc_write                   (desc_write),
    .block_write                  (block_write),
    .block_start                  (block_start)
  );

  // **************************************************
  // output buffers, both cleared by flush
  // **************************************************
  sync_fifo #(.width(line_width)) u_desc_fifo (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .wr_data     (m_readdata),
    .wr_en       (desc_write),
    .rd_en       (descriptor_valid && descriptor_ready),
    .rd_data     (descriptor),
    .empty       (desc_empty),
    .full        (),
    .almost_full (desc_almost_full),  // feeds the read throttle
    .used        ()
  );

  sync_fifo #(.width(address_width)) u_block_fifo (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .wr_data     (block_start),
    .wr_en       (block_write),
    .rd_en       (block_address_valid && block_address_ready),
    .rd_data     (block_address),
    .empty       (block_empty),
    .full        (),
    .almost_full (),
    .used        ()
  );

  assign descriptor_valid    = !desc_empty;
  assign block_address_valid = !block_empty;

endmodule

// ==== hdl/line_read_master.sv ====
// issues single line reads and decodes every line that returns
module line_read_master
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  fetch_state_t state,
  input  address_t     new_descriptor_location,
  input  logic         load_new_descriptor_location,
  input  line_t        m_readdata,
  input  logic         m_readdatavalid,
  input  logic         m_waitrequest,
  input  logic         desc_almost_full,  // descriptor buffer is half full
  output address_t     m_address,
  output logic         m_read,
  output logic         read_stalled,
  output logic         first_owned,
  output logic         first_single,
  output logic         first_unowned,
  output logic         last_read_posted,
  output logic         desc_write,
  output logic         block_write,
  output address_t     block_start
);

  logic         line_owned;
  logic         line_first;
  block_count_t line_size;
  address_t     line_next;
  logic         read_accepted;
  address_t     next_address;
  address_t     address_counter;
  logic         step_address;
  block_count_t block_counter;
  reads_t       reads_in_flight;
  logic         too_many_reads;
  logic         first_read_done;
  logic         read_active;
  logic         set_read_active;
  logic         clear_read_active;

  // **************************************************
  // decode of the returned line
  // **************************************************
  assign line_owned = m_readdata[owned_bit];
  assign line_first = m_readdata[format_first_bit];
  assign line_size  = m_readdata[block_size_lsb +: block_count_width];
  assign line_next  = m_readdata[next_lsb +: address_width];

  assign read_accepted = m_read && !m_waitrequest;
  assign read_stalled  = m_read && m_waitrequest;

  // only a line read in load_first can open a block
  assign first_owned      = m_readdatavalid && line_owned && line_first && (state == load_first);
  assign first_single     = first_owned && (line_size == '0);
  assign first_unowned    = m_readdatavalid && !line_owned;  // end of the chain was hit
  assign last_read_posted = (state == load_rest) && read_accepted && (block_counter == 8'd1);

  assign desc_write  = m_readdatavalid && line_owned;  // lines pass through untouched
  assign block_write = first_owned;
  assign block_start = address_counter;  // still points at the first line on this cycle

  // **************************************************
  // address and block counters
  // **************************************************
  // an unowned first line leaves this alone so a retry reads the same block again
  always_ff @(posedge clk)
  begin
    if (load_new_descriptor_location)
    begin
      next_address <= new_descriptor_location;
    end
    else if (first_owned)
    begin
      next_address <= line_next;  // the next block is known as soon as the first line is back
    end
  end

  // the first line steps the counter on its return, the rest step it as each read is accepted
  assign step_address = first_owned || ((state == load_rest) && read_accepted);

  always_ff @(posedge clk)
  begin
    if (state == load_counter)
    begin
      address_counter <= next_address;
    end
    else if (step_address)
    begin
      address_counter <= address_counter + address_t'(line_bytes);
    end
  end

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      block_counter <= '0;
    end
    else if (first_owned)
    begin
      block_counter <= line_size;
    end
    else if ((state == load_rest) && read_accepted)
    begin
      block_counter <= block_counter - 1'b1;  // reaches zero with the last read of the block
    end
  end

  // **************************************************
  // read issue and throttling
  // **************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      reads_in_flight <= '0;
    end
    else
    begin
      reads_in_flight <= reads_in_flight + reads_t'(read_accepted) - reads_t'(m_readdatavalid);
    end
  end

  // half a buffer in flight or half a buffer stored, either keeps the total within the depth
  assign too_many_reads = reads_in_flight[fifo_depth_log2-1] || desc_almost_full;

  // load_first gets exactly one read, this remembers that it went out
  always_ff @(posedge clk)
  begin
    if (reset || (state == load_counter))
    begin
      first_read_done <= 1'b0;
    end
    else if ((state == load_first) && read_accepted)
    begin
      first_read_done <= 1'b1;
    end
  end

  assign set_read_active = ((state == load_first) && !first_read_done && !too_many_reads) ||
                           ((state == load_rest) && !too_many_reads);

  // a read that has been raised only drops once it is accepted
  assign clear_read_active = ((state == load_first) && read_accepted) ||
                             ((state == load_rest) && read_accepted && too_many_reads) ||
                             last_read_posted ||
                             ((state == idle) && !read_stalled);

  always_ff @(posedge clk)
  begin
    if (reset || clear_read_active)
    begin
      read_active <= 1'b0;  // clear beats set
    end
    else if (set_read_active)
    begin
      read_active <= 1'b1;
    end
  end

  assign m_address = address_counter;
  assign m_read    = read_active;

  // a stalled request holds across the sequencer and the counters until it is taken
  a_stall_hold: assert property (@(posedge clk) disable iff (reset)
    read_stalled |=> (m_read && $stable(m_address)));

endmodule

// ==== hdl/fetch_sequencer.sv ====
// walks the descriptor chain one block at a time
//
//   idle -> load_counter -> load_first -> load_rest -> load_counter ...
//   a single line block skips load_rest and goes straight back to load_counter
//   an unowned first line ends in retry_wait or wait_reload, both lead back to idle
module fetch_sequencer
  import fetch_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         flush,
  input  logic         enable_fetch,
  input  logic         enable_descriptor_timeout,     // poll the chain end instead of waiting
  input  logic         load_new_descriptor_location,  // host strobe, also ends wait_reload
  input  timeout_t     descriptor_timeout,            // cycles between polls of the chain end
  input  logic         read_stalled,
  input  logic         first_owned,
  input  logic         first_single,
  input  logic         first_unowned,
  input  logic         last_read_posted,
  output fetch_state_t state,
  output logic         fetch_idle
);

  timeout_t timeout_counter;
  logic     stop_request;
  logic     refetch_trigger;
  logic     refetch_trigger_d1;

  // a stalled read has to be accepted first or the read port would change under it
  assign stop_request = (flush || !enable_fetch) && !read_stalled;

  // **************************************************
  // state register
  // **************************************************
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= idle;
    end
    else if (stop_request)
    begin
      state <= idle;  // disabled or flushed, park here until fetching is enabled again
    end
    else
    begin
      case (state)
        idle:
        begin
          if (enable_fetch)
          begin
            state <= load_counter;  // the host loaded the first block location beforehand
          end
        end
        load_counter:
        begin
          state <= load_first;  // one cycle so the address counter is loaded before the read
        end
        load_first:
        begin
          // the order matters here since a single line block is also an owned one
          if (first_unowned)
          begin
            state <= enable_descriptor_timeout ? retry_wait : wait_reload;
          end
          else if (first_single)
          begin
            state <= load_counter;  // nothing follows the first line so move to the next block
          end
          else if (first_owned)
          begin
            state <= load_rest;
          end
        end
        load_rest:
        begin
          if (last_read_posted)
          begin
            state <= load_counter;  // the rest of the block is still in flight, that is fine
          end
        end
        retry_wait:
        begin
          if (refetch_trigger_d1)
          begin
            state <= idle;  // idle then load_counter reloads the same block start
          end
        end
        wait_reload:
        begin
          if (load_new_descriptor_location)
          begin
            state <= idle;
          end
        end
        default:
        begin
          state <= idle;
        end
      endcase
    end
  end

  // **************************************************
  // retry timeout
  // **************************************************
  // the count sits at the preload outside retry_wait and runs freely inside it
  always_ff @(posedge clk)
  begin
    if (reset || (state != retry_wait))
    begin
      timeout_counter <= timeout_preload;
    end
    else
    begin
      timeout_counter <= timeout_counter + 1'b1;
    end
  end

  // greater or equal so that a timeout programmed below the preload still fires
  assign refetch_trigger = (state == retry_wait) && (timeout_counter >= descriptor_timeout);

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      refetch_trigger_d1 <= 1'b0;
    end
    else
    begin
      refetch_trigger_d1 <= refetch_trigger;  // the extra cycle back to idle
    end
  end

  assign fetch_idle = (state == idle) || (state == wait_reload);  // no reads will be started

  // the state register is three bits wide but only six codes are ever entered
  a_state_legal: assert property (@(posedge clk) disable iff (reset)
    state inside {idle, load_counter, load_first, load_rest, retry_wait, wait_reload});

endmodule

// ==== hdl/sync_fifo.sv ====
// show-ahead buffer that keeps the head entry on rd_data whenever empty is low
module sync_fifo
  import fetch_pkg::*;
#(
  parameter int width = line_width
)
(
  input  logic             clk,
  input  logic             reset,
  input  logic             flush,        // drops every entry in one cycle
  input  logic [width-1:0] wr_data,
  input  logic             wr_en,
  input  logic             rd_en,        // pops the head entry
  output logic [width-1:0] rd_data,
  output logic             empty,
  output logic             full,
  output logic             almost_full,  // half the depth or more is in use
  output fill_t            used
);

  logic [width-1:0]           mem [fifo_depth];
  logic [fifo_depth_log2-1:0] wr_ptr;
  logic [fifo_depth_log2-1:0] rd_ptr;

  // entries are written at the tail pointer
  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk)
  begin
    if (reset || flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      used   <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      used <= used + fill_t'(wr_en) - fill_t'(rd_en);  // both at once leaves the count alone
    end
  end

  assign rd_data     = mem[rd_ptr];  // a write into an empty buffer shows here one cycle later
  assign empty       = (used == '0);
  assign full        = (used == fill_t'(fifo_depth));
  assign almost_full = (used >= fill_t'(fifo_half));

  // the producer throttles itself on almost_full, so a full buffer must never see a write
  a_no_overflow: assert property (@(posedge clk) disable iff (reset || flush)
    !(wr_en && full));

  // the consumer only pops while it sees a valid head
  a_no_underflow: assert property (@(posedge clk) disable iff (reset || flush)
    !(rd_en && empty));

endmodule

// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

  // **************************************************
  // widths and the types that carry them
  // **************************************************
  localparam int address_width = 48;                  // byte address into host memory
  typedef logic [address_width-1:0] address_t;

  localparam int line_width = 512;                    // one descriptor per line
  typedef logic [line_width-1:0] line_t;

  localparam int line_bytes = line_width / 8;         // 64 byte step between lines

  localparam int fifo_depth_log2 = 6;
  localparam int fifo_depth = 2 ** fifo_depth_log2;   // 64 entries per buffer
  localparam int fifo_half = fifo_depth / 2;          // throttle point for new reads
  typedef logic [fifo_depth_log2:0] fill_t;           // one extra bit so full differs from empty
  typedef logic [fifo_depth_log2-1:0] reads_t;        // top bit doubles as the half-way flag

  localparam int block_count_width = 8;
  typedef logic [block_count_width-1:0] block_count_t;  // lines that follow the first one

  typedef logic [15:0] timeout_t;
  localparam timeout_t timeout_preload = 16'd6;       // covers pipeline and state change cycles

  // **************************************************
  // field positions inside a descriptor line
  // **************************************************
  localparam int format_first_bit = 0;                // set only in the first line of a block
  localparam int block_size_lsb = 8;
  localparam int owned_bit = 16;                      // hardware may consume the line when set
  localparam int next_lsb = 448;                      // low bits of the next block address

  // block walk states
  typedef enum logic [2:0] {
    idle,
    load_counter,
    load_first,
    load_rest,
    retry_wait,
    wait_reload
  } fetch_state_t;

endpackage
